// ==== flist.f ====
+incdir+src
src/uop_pkg.sv
src/rename_pkg.sv
src/first_bit_finder.sv
src/free_list.sv
src/rat.sv
src/rename_stage.sv
testbench/tb_rename_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module tb_rename_stage \
  -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rename_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// ==== src/first_bit_finder.sv ====
`timescale 1ns/10ps

// Priority encoder, lowest index whose bit equals find_set
module first_bit_finder #(
  parameter  int WIDTH = 64,
  localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0] in_bits,
  input  logic             find_set,     // 1 looks for a set bit, 0 for a clear bit
  output logic [IDX_W-1:0] first_index,  // Zero when nothing found
  output logic             found
);

  logic [WIDTH-1:0] target;  // Ones wherever the bit matches find_set

  assign target = find_set ? in_bits : ~in_bits;

  // Walk from the top down so the lowest match is written last
  always_comb begin
    first_index = '0;
    found       = 1'b0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (target[i]) begin
        first_index = IDX_W'(i);
        found       = 1'b1;
      end
    end
  end

endmodule

// ==== src/free_list.sv ====
`timescale 1ns/10ps
`include "rename_config.svh"

// Physical register free list kept as an in-use bitmap
// Offers the two lowest free registers each cycle
module free_list (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [1:0]                             taken,       // Offer i consumed this cycle
  input  logic [1:0]                             free_valid,  // Commit release
  input  logic [1:0][rename_pkg::PHYS_IDX_W-1:0] free_reg,
  output logic [1:0]                             avail,       // Offer i exists
  output logic [1:0][rename_pkg::PHYS_IDX_W-1:0] avail_reg    // Lowest, second lowest free
);
  import rename_pkg::*;

  logic [`NUM_PHYS_REGS-1:0] in_use_q;       // 1 = allocated
  logic [`NUM_PHYS_REGS-1:0] in_use_d;
  logic [`NUM_PHYS_REGS-1:0] in_use_masked;  // First offer hidden

  // Lowest clear bit is the first offer
  first_bit_finder #(
    .WIDTH(`NUM_PHYS_REGS)
  ) first_free_i (
    .in_bits    (in_use_q),
    .find_set   (1'b0),
    .first_index(avail_reg[0]),
    .found      (avail[0])
  );

  // Hide the first offer to get the second
  // If nothing was found the index is 0, which is pinned in use anyway
  always_comb begin
    in_use_masked               = in_use_q;
    in_use_masked[avail_reg[0]] = 1'b1;
  end

  first_bit_finder #(
    .WIDTH(`NUM_PHYS_REGS)
  ) second_free_i (
    .in_bits    (in_use_masked),
    .find_set   (1'b0),
    .first_index(avail_reg[1]),
    .found      (avail[1])
  );

  // Takes and frees land together
  // Only regs in use get freed, and those are never on offer
  always_comb begin
    in_use_d = in_use_q;
    for (int i = 0; i < 2; i++) begin
      if (taken[i]) in_use_d[avail_reg[i]] = 1'b1;
    end
    for (int i = 0; i < 2; i++) begin
      if (free_valid[i] && in_use_q[free_reg[i]]) begin
        in_use_d[free_reg[i]] = 1'b0;  // Freeing a free reg is a no-op
      end
    end
    in_use_d[0] = 1'b1;  // Phys 0 backs arch 0 forever
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
        in_use_q[i] <= (i < RESET_FREE_BASE);  // Identity mapping holds the low regs
      end
    end else begin
      in_use_q <= in_use_d;
    end
  end

endmodule

// ==== src/rat.sv ====
`timescale 1ns/10ps
`include "rename_config.svh"

// Register alias table for a two-wide rename group
// Looks up sources, grants new dests and registers the result for the ROB
module rat (
  input  logic                                   clk,
  input  logic                                   rst,
  input  uop_pkg::uop_word_u [1:0]               instr,
  input  logic [1:0]                             instr_valid,
  input  logic [1:0][`PC_W-1:0]                  pc,
  output logic                                   ready,
  input  logic [1:0]                             avail,
  input  logic [1:0][rename_pkg::PHYS_IDX_W-1:0] avail_reg,
  output logic [1:0]                             taken,
  input  logic                                   rob_stall,
  output logic [1:0]                             rob_valid,
  output logic [1:0][`PC_W-1:0]                  rob_pc,
  output logic [1:0][rename_pkg::ARCH_IDX_W-1:0] rob_dst_arch,
  output logic [1:0][rename_pkg::PHYS_IDX_W-1:0] rob_dst_phys,
  output logic [1:0][rename_pkg::PHYS_IDX_W-1:0] rob_old_phys,  // Freed by the ROB at commit
  output logic [1:0][rename_pkg::PHYS_IDX_W-1:0] rob_src1_phys,
  output logic [1:0][rename_pkg::PHYS_IDX_W-1:0] rob_src2_phys
);
  import rename_pkg::*;
  import uop_pkg::*;

  logic [PHYS_IDX_W-1:0]      map_q [`NUM_ARCH_REGS];  // Arch to phys
  logic                       started_q;               // Low through reset
  logic [1:0][ARCH_IDX_W-1:0] dst_arch;
  logic [1:0][ARCH_IDX_W-1:0] src1_arch;
  logic [1:0][ARCH_IDX_W-1:0] src2_arch;
  logic [1:0]                 needs_reg;  // Valid, has a dest, dest not arch 0
  logic [1:0][PHYS_IDX_W-1:0] new_phys;
  logic [1:0][PHYS_IDX_W-1:0] old_phys;
  logic [1:0][PHYS_IDX_W-1:0] src1_phys;
  logic [1:0][PHYS_IDX_W-1:0] src2_phys;

  // Field decode, register positions are common to both views
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      dst_arch[s]  = instr[s].rr.dst;
      src1_arch[s] = instr[s].rr.src1;
      // Imm form has no src2, read arch 0 instead
      src2_arch[s] = (instr[s].rr.fmt == FMT_RR) ? instr[s].rr.src2 : ZERO_REG;
      needs_reg[s] = instr_valid[s] && instr[s].rr.has_dst && (instr[s].rr.dst != ZERO_REG);
    end
  end

  // Always asks for two free regs, even for a group that needs fewer
  assign ready = started_q && !rob_stall && avail[0] && avail[1];

  // taken is per offer, not per slot
  // A lone slot 1 dest still consumes offer 0
  assign taken[0] = ready && (needs_reg[0] || needs_reg[1]);
  assign taken[1] = ready && needs_reg[0] && needs_reg[1];

  always_comb begin
    // Slot 0 reads the table as is
    old_phys[0]  = map_q[dst_arch[0]];
    new_phys[0]  = needs_reg[0] ? avail_reg[0] : old_phys[0];  // No dest keeps current map
    src1_phys[0] = map_q[src1_arch[0]];
    src2_phys[0] = map_q[src2_arch[0]];

    // Slot 1 sees slot 0's new dest through the bypass
    src1_phys[1] = (needs_reg[0] && (src1_arch[1] == dst_arch[0])) ? new_phys[0]
                                                                    : map_q[src1_arch[1]];
    src2_phys[1] = (needs_reg[0] && (src2_arch[1] == dst_arch[0])) ? new_phys[0]
                                                                    : map_q[src2_arch[1]];
    old_phys[1]  = (needs_reg[0] && (dst_arch[1] == dst_arch[0])) ? new_phys[0]
                                                                   : map_q[dst_arch[1]];
    // Grants follow slot order
    if (needs_reg[1]) begin
      new_phys[1] = needs_reg[0] ? avail_reg[1] : avail_reg[0];
    end else begin
      new_phys[1] = old_phys[1];
    end
  end

  // Table and output valids
  always_ff @(posedge clk) begin
    if (rst) begin
      started_q <= 1'b0;
      rob_valid <= '0;
      for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
        map_q[i] <= PHYS_IDX_W'(i);  // Identity mapping
      end
    end else begin
      started_q <= 1'b1;
      if (ready) begin
        rob_valid <= instr_valid;
        // Slot 1 written last, so it wins on equal dest
        for (int s = 0; s < 2; s++) begin
          if (needs_reg[s]) map_q[dst_arch[s]] <= new_phys[s];
        end
      end else if (!rob_stall) begin
        rob_valid <= '0;  // ROB took the last group, nothing new behind it
      end
      // Stalled: hold
    end
  end

  // Payload to the ROB, loaded only on acceptance so it holds under stall
  always_ff @(posedge clk) begin
    if (ready) begin
      rob_pc        <= pc;
      rob_dst_arch  <= dst_arch;
      rob_dst_phys  <= new_phys;
      rob_old_phys  <= old_phys;
      rob_src1_phys <= src1_phys;
      rob_src2_phys <= src2_phys;
    end
  end

endmodule

// ==== src/rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Sizing of the rename stage
// Shared by the packages, the RTL and the testbench

// Architectural register file, one word per entry
`define NUM_ARCH_REGS 32

// Physical register file
// Must be at least NUM_ARCH_REGS + 2 so that a group can ever rename
`define NUM_PHYS_REGS 64

// Program counter width carried through to the ROB
`define PC_W 32

`endif

// ==== src/rename_pkg.sv ====
`include "rename_config.svh"

// Index widths and reset state of the renaming tables
package rename_pkg;

  // Index widths follow the configured register counts
  localparam int ARCH_IDX_W = $clog2(`NUM_ARCH_REGS);
  localparam int PHYS_IDX_W = $clog2(`NUM_PHYS_REGS);

  // Arch reg 0 is hardwired, always maps to phys reg 0 and is never renamed
  localparam logic [ARCH_IDX_W-1:0] ZERO_REG = '0;

  // After reset arch reg i sits in phys reg i
  // So the first free phys reg comes right after the arch file
  localparam int RESET_FREE_BASE = `NUM_ARCH_REGS;

endpackage

// ==== src/rename_stage.sv ====
`timescale 1ns/10ps
`include "rename_config.svh"

// Two-wide rename stage, RAT plus free list
module rename_stage (
  input  logic                                   clk,
  input  logic                                   rst,
  input  uop_pkg::uop_word_u [1:0]               instr,
  input  logic [1:0]                             instr_valid,
  input  logic [1:0][`PC_W-1:0]                  pc,
  output logic                                   ready,
  output logic [1:0]                             rob_valid,
  output logic [1:0][`PC_W-1:0]                  rob_pc,
  output logic [1:0][rename_pkg::ARCH_IDX_W-1:0] rob_dst_arch,
  output logic [1:0][rename_pkg::PHYS_IDX_W-1:0] rob_dst_phys,
  output logic [1:0][rename_pkg::PHYS_IDX_W-1:0] rob_old_phys,
  output logic [1:0][rename_pkg::PHYS_IDX_W-1:0] rob_src1_phys,
  output logic [1:0][rename_pkg::PHYS_IDX_W-1:0] rob_src2_phys,
  input  logic                                   rob_stall,
  input  logic [1:0]                             free_valid,  // From commit
  input  logic [1:0][rename_pkg::PHYS_IDX_W-1:0] free_reg
);
  import rename_pkg::*;

  logic [1:0]                 avail;
  logic [1:0][PHYS_IDX_W-1:0] avail_reg;
  logic [1:0]                 taken;

  rat rat_i (
    .clk          (clk),
    .rst          (rst),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .pc           (pc),
    .ready        (ready),
    .avail        (avail),
    .avail_reg    (avail_reg),
    .taken        (taken),
    .rob_stall    (rob_stall),
    .rob_valid    (rob_valid),
    .rob_pc       (rob_pc),
    .rob_dst_arch (rob_dst_arch),
    .rob_dst_phys (rob_dst_phys),
    .rob_old_phys (rob_old_phys),
    .rob_src1_phys(rob_src1_phys),
    .rob_src2_phys(rob_src2_phys)
  );

  // Commit frees bypass the RAT
  free_list free_list_i (
    .clk       (clk),
    .rst       (rst),
    .taken     (taken),
    .free_valid(free_valid),
    .free_reg  (free_reg),
    .avail     (avail),
    .avail_reg (avail_reg)
  );

endmodule

// ==== src/uop_pkg.sv ====
// Decoded micro-op word as it arrives from decode
package uop_pkg;

  localparam int REG_FIELD_W = 5;   // One architectural register index
  localparam int FUNCT_W     = 15;  // Function bits of the reg-reg form
  localparam int IMM_W       = 20;  // Immediate of the reg-imm form

  // Values of the format bit
  localparam logic FMT_RR = 1'b0;  // Two register sources
  localparam logic FMT_RI = 1'b1;  // One register source plus immediate

  // Same 32-bit word seen two ways
  // Format bit and register fields line up in both views
  typedef union packed {
    struct packed {
      logic                   fmt;      // FMT_RR here
      logic                   has_dst;  // Writes a register
      logic [REG_FIELD_W-1:0] dst;
      logic [REG_FIELD_W-1:0] src1;
      logic [REG_FIELD_W-1:0] src2;
      logic [FUNCT_W-1:0]     funct;
    } rr;
    struct packed {
      logic                   fmt;      // FMT_RI here
      logic                   has_dst;
      logic [REG_FIELD_W-1:0] dst;
      logic [REG_FIELD_W-1:0] src1;
      logic [IMM_W-1:0]       imm;      // Takes the place of src2 and funct
    } ri;
  } uop_word_u;

endpackage

// ==== testbench/tb_rename_stage.sv ====
`timescale 1ns/10ps
`include "rename_config.svh"

// Random two-wide groups against a sequential rename model
module tb_rename_stage;
  import rename_pkg::*;
  import uop_pkg::*;

  localparam int NUM_GROUPS = 3000;
  localparam int MAX_CYCLES = NUM_GROUPS * 10;  // Stalls and empty phases leave idle cycles

  logic                       clk, rst, ready, rob_stall;
  uop_word_u [1:0]            instr;
  logic [1:0]                 instr_valid, rob_valid, free_valid;
  logic [1:0][`PC_W-1:0]      pc, rob_pc;
  logic [1:0][ARCH_IDX_W-1:0] rob_dst_arch;
  logic [1:0][PHYS_IDX_W-1:0] rob_dst_phys, rob_old_phys, rob_src1_phys, rob_src2_phys;
  logic [1:0][PHYS_IDX_W-1:0] free_reg;

  int                         seed = 32'ha3ef_5a08;
  logic [PHYS_IDX_W-1:0]      model_rat [`NUM_ARCH_REGS];  // Committed view of the table
  logic [PHYS_IDX_W-1:0]      next_rat [`NUM_ARCH_REGS];   // Table after the current group
  logic [`NUM_PHYS_REGS-1:0]  model_used;                  // 1 = allocated
  logic [PHYS_IDX_W-1:0]      pending [$];                 // Old regs waiting for commit
  logic [1:0]                 need, exp_valid;
  logic [1:0][PHYS_IDX_W-1:0] nx_dst, nx_old, nx_src1, nx_src2;
  logic [1:0][PHYS_IDX_W-1:0] exp_dst, exp_old, exp_src1, exp_src2;
  logic [1:0][`PC_W-1:0]      exp_pc;
  logic [1:0][ARCH_IDX_W-1:0] exp_dst_arch;
  logic                       started, exp_ready;
  int                         groups_done, cycle_cnt, starved;

  rename_stage dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // Low regs half the time so bypass hits and dst 0 show up often
  function automatic logic [ARCH_IDX_W-1:0] rand_reg();
    logic [31:0] r;
    r = rnd();
    return r[5] ? ARCH_IDX_W'(r[1:0]) : r[4:0];
  endfunction

  function automatic logic [PHYS_IDX_W-1:0] lowest_free(input logic [`NUM_PHYS_REGS-1:0] used);
    logic hit = 1'b0;
    lowest_free = '0;
    for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
      if (!used[i] && !hit) begin
        lowest_free = PHYS_IDX_W'(i);
        hit         = 1'b1;
      end
    end
  endfunction

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_phys(input string name, input logic [PHYS_IDX_W-1:0] got, exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_arch(input string name, input logic [ARCH_IDX_W-1:0] got, exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_pc(input string name, input logic [`PC_W-1:0] got, exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Payload only matters for valid slots
  task automatic compare_outputs();
    for (int s = 0; s < 2; s++) begin
      check_flag($sformatf("rob_valid[%0d]", s), rob_valid[s], exp_valid[s]);
      if (exp_valid[s]) begin
        check_pc($sformatf("rob_pc[%0d]", s), rob_pc[s], exp_pc[s]);
        check_arch($sformatf("rob_dst_arch[%0d]", s), rob_dst_arch[s], exp_dst_arch[s]);
        check_phys($sformatf("rob_dst_phys[%0d]", s), rob_dst_phys[s], exp_dst[s]);
        check_phys($sformatf("rob_old_phys[%0d]", s), rob_old_phys[s], exp_old[s]);
        check_phys($sformatf("rob_src1_phys[%0d]", s), rob_src1_phys[s], exp_src1[s]);
        check_phys($sformatf("rob_src2_phys[%0d]", s), rob_src2_phys[s], exp_src2[s]);
      end
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    int          k;
    rob_stall = (rnd() % 5) == 0;  // About one cycle in five
    for (int s = 0; s < 2; s++) begin
      r                   = rnd();
      instr[s]            = rnd();
      instr[s].rr.has_dst = r[1:0] != 2'd0;
      instr[s].rr.dst     = rand_reg();
      instr[s].rr.src1    = rand_reg();
      if (instr[s].rr.fmt == FMT_RR) instr[s].rr.src2 = rand_reg();
      instr_valid[s]      = r[3:2] != 2'd0;
      pc[s]               = rnd();
      free_valid[s]       = 1'b0;
      free_reg[s]         = '0;
      // Commits only in every other 64-cycle phase, so the list drains and refills
      if (cycle_cnt[6] && pending.size() > 0 && r[5:4] != 2'd0) begin
        k             = int'(rnd() % pending.size());
        free_valid[s] = 1'b1;
        free_reg[s]   = pending[k];
        pending.delete(k);
      end else if (r[9:7] == 3'd0) begin
        free_valid[s] = 1'b1;  // Release of reg 0, must change nothing
      end else if (r[9:7] == 3'd1) begin
        free_valid[s] = 1'b1;  // Release of the reg on offer, which is already free
        free_reg[s]   = lowest_free(model_used);
      end
    end
  endtask

  // Rename the slots one after another, slot 1 sees slot 0's result in next_rat
  task automatic compute_group();
    logic [PHYS_IDX_W-1:0] offer [2];
    logic                  next_offer;
    offer[0]   = lowest_free(model_used);
    offer[1]   = lowest_free(model_used | (`NUM_PHYS_REGS'(1) << offer[0]));
    next_offer = 1'b0;
    next_rat   = model_rat;
    for (int s = 0; s < 2; s++) begin
      need[s]    = instr_valid[s] && instr[s].rr.has_dst && (instr[s].rr.dst != ZERO_REG);
      nx_src1[s] = next_rat[instr[s].rr.src1];
      nx_src2[s] = (instr[s].ri.fmt == FMT_RI) ? next_rat[0] : next_rat[instr[s].rr.src2];
      nx_old[s]  = next_rat[instr[s].rr.dst];
      nx_dst[s]  = nx_old[s];  // No dest, mapping stays
      if (need[s]) begin
        nx_dst[s]                   = offer[next_offer];
        next_offer                  = 1'b1;
        next_rat[instr[s].rr.dst]   = nx_dst[s];
      end
    end
  endtask

  task automatic update_model();
    logic [`NUM_PHYS_REGS-1:0] was_used;  // Bitmap before this edge
    was_used = model_used;
    if (exp_ready) begin
      model_rat    = next_rat;
      exp_valid    = instr_valid;
      exp_pc       = pc;
      exp_dst      = nx_dst;
      exp_old      = nx_old;
      exp_src1     = nx_src1;
      exp_src2     = nx_src2;
      for (int s = 0; s < 2; s++) begin
        exp_dst_arch[s] = instr[s].rr.dst;
        if (need[s]) begin
          model_used[nx_dst[s]] = 1'b1;
          pending.push_back(nx_old[s]);  // Freed once this op commits
        end
      end
      groups_done++;
    end else if (!rob_stall) begin
      exp_valid = '0;
    end
    // Only regs in use before the edge can be released
    for (int s = 0; s < 2; s++) begin
      if (free_valid[s] && free_reg[s] != '0 && was_used[free_reg[s]]) begin
        model_used[free_reg[s]] = 1'b0;
      end
    end
    started = 1'b1;
  endtask

  initial begin
    rst         = 1'b1;
    instr       = '0;
    instr_valid = '0;
    pc          = '0;
    rob_stall   = 1'b0;
    free_valid  = '0;
    free_reg    = '0;
    started     = 1'b0;
    exp_valid   = '0;
    groups_done = 0;
    cycle_cnt   = 0;
    starved     = 0;
    for (int i = 0; i < `NUM_PHYS_REGS; i++) model_used[i] = (i < RESET_FREE_BASE);
    for (int i = 0; i < `NUM_ARCH_REGS; i++) model_rat[i] = PHYS_IDX_W'(i);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("ready", ready, 1'b0);  // Still in reset
    rst = 1'b0;
    while (groups_done < NUM_GROUPS) begin
      if (cycle_cnt >= MAX_CYCLES) begin
        $display("Timeout after %0d cycles, only %0d groups renamed", cycle_cnt, groups_done);
        stop_run();
      end
      compare_outputs();
      drive_inputs();
      compute_group();
      #1;
      exp_ready = started && !rob_stall && (`NUM_PHYS_REGS - $countones(model_used)) >= 2;
      if (started && !rob_stall && !exp_ready) starved++;  // Held back by the free list
      check_flag("ready", ready, exp_ready);
      @(posedge clk);
      update_model();
      cycle_cnt++;
      @(negedge clk);
    end
    compare_outputs();
    if (starved == 0) begin
      $display("The free list never ran short, so the stall on too few registers was not seen");
      stop_run();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule
